// ==== verilog/line_pkg.sv ====
// types shared by the line drawer and the scan-out path
// palette is fixed 12-bit rgb, entry 0 is the background colour
package line_pkg;

    typedef logic signed [15:0] coord_t;  // screen and framebuffer coords
    typedef logic [3:0] cidx_t;           // palette index
    typedef logic [3:0] chan_t;           // one colour channel

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_cmd_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pix_out_t;

    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;
        logic   vsync;
        logic   de;
        logic   frame;  // first pixel of line 0
        logic   line;   // first pixel of every line
    } raster_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FRAME,
        DRAW,
        DONE
    } draw_state_t;

    // 16 colours, rrrr_gggg_bbbb
    localparam logic [11:0] PALETTE [16] = '{
        12'h000, 12'h235, 12'h725, 12'h085,
        12'hA53, 12'h555, 12'hCCC, 12'hFFE,
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,
        12'h2AF, 12'h879, 12'hF7A, 12'hFCA
    };

endpackage

// ==== verilog/display_timings.sv ====
`timescale 1ns/1ns

// raster order is active, front porch, sync, back porch on both axes
// hsync and vsync are active high; raster lags the raw counters by one clock
module display_timings import line_pkg::*; #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FP     = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BP     = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FP     = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BP     = 20
) (
    input  logic    clk_pix,
    input  logic    rst_n,
    output raster_t raster
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HS_BEG  = H_ACTIVE + H_FP;
    localparam int HS_END  = HS_BEG + H_SYNC;
    localparam int VS_BEG  = V_ACTIVE + V_FP;
    localparam int VS_END  = VS_BEG + V_SYNC;

    coord_t  hc;   // raw horizontal position
    coord_t  vc;   // raw line number
    raster_t nxt;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            hc <= '0;
            vc <= '0;
        end else if (hc == coord_t'(H_TOTAL - 1)) begin
            hc <= '0;
            if (vc == coord_t'(V_TOTAL - 1)) begin
                vc <= '0;
            end else begin
                vc <= vc + coord_t'(1);
            end
        end else begin
            hc <= hc + coord_t'(1);
        end
    end

    // decode from the raw counters
    always_comb begin
        nxt.sx    = hc;
        nxt.sy    = vc;
        nxt.hsync = (hc >= coord_t'(HS_BEG)) && (hc < coord_t'(HS_END));
        nxt.vsync = (vc >= coord_t'(VS_BEG)) && (vc < coord_t'(VS_END));  // whole lines
        nxt.de    = (hc < coord_t'(H_ACTIVE)) && (vc < coord_t'(V_ACTIVE));
        nxt.frame = (hc == '0) && (vc == '0);
        nxt.line  = (hc == '0);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            raster <= '0;
        end else begin
            raster <= nxt;
        end
    end

endmodule

// ==== verilog/draw_line.sv ====
`timescale 1ns/1ns

// bresenham engine, one point per clock, all eight octants
// spans must stay within +/-16383 so the doubled error term fits coord_t
module draw_line import line_pkg::*; (
    input  logic   clk_pix,
    input  logic   rst_n,
    input  logic   start,
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    output coord_t x,
    output coord_t y,
    output logic   drawing,
    output logic   done
);

    coord_t xe, ye;      // latched end point
    coord_t dx, dy;      // dy is held as minus |dy|
    coord_t dx_in, dy_in;
    coord_t err;
    coord_t e2;
    logic   right, down; // step directions
    logic   step_x, step_y;
    logic   last;

    // deltas of the incoming command
    always_comb begin
        dx_in = (x1 >= x0) ? x1 - x0 : x0 - x1;
        dy_in = (y1 >= y0) ? y0 - y1 : y1 - y0;  // negative magnitude
    end

    always_comb begin
        e2     = err <<< 1;
        step_x = (e2 >= dy);   // ties step both axes
        step_y = (e2 <= dx);
        last   = (x == xe) && (y == ye);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            drawing <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                drawing <= 1'b1;
            end else if (drawing && last) begin
                drawing <= 1'b0;
                done    <= 1'b1;  // cycle after the final point
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (start) begin
            x     <= x0;
            y     <= y0;
            xe    <= x1;
            ye    <= y1;
            dx    <= dx_in;
            dy    <= dy_in;
            err   <= dx_in + dy_in;
            right <= (x1 >= x0);
            down  <= (y1 >= y0);
        end else if (drawing && !last) begin
            if (step_x) begin
                x <= right ? x + coord_t'(1) : x - coord_t'(1);
            end
            if (step_y) begin
                y <= down ? y + coord_t'(1) : y - coord_t'(1);
            end
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
        end
    end

endmodule

// ==== verilog/framebuffer.sv ====
`timescale 1ns/1ns

// index memory with a write port for the drawer and a scan-out read port
// H_ACTIVE and V_ACTIVE must be multiples of SCALE; pix lags raster by 2 clocks
module framebuffer import line_pkg::*; #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720,
    parameter int SCALE    = 4
) (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  raster_t  raster,
    input  logic     we,
    input  coord_t   x,
    input  coord_t   y,
    input  cidx_t    cidx,
    output pix_out_t pix
);

    localparam int FB_W  = H_ACTIVE / SCALE;
    localparam int FB_H  = V_ACTIVE / SCALE;
    localparam int DEPTH = FB_W * FB_H;
    localparam int ADDRW = $clog2(DEPTH);
    localparam int SUBW  = (SCALE > 1) ? $clog2(SCALE) : 1;

    cidx_t mem [DEPTH];

    logic             in_fb;
    logic [ADDRW-1:0] wr_addr;
    logic [ADDRW-1:0] rd_addr;
    logic [ADDRW-1:0] row_base;  // address of column 0 in the current fb row
    logic [ADDRW-1:0] fx;        // fb column
    logic [SUBW-1:0]  sub_x;
    logic [SUBW-1:0]  sub_y;
    cidx_t            rd_idx;
    logic             hsync_q, vsync_q, de_q;
    logic [11:0]      rgb;
    chan_t            red, green, blue;

    // background index 0 at configuration
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // clip before writing, out-of-range points never wrap
    always_comb begin
        in_fb   = (x >= 0) && (x < coord_t'(FB_W)) && (y >= 0) && (y < coord_t'(FB_H));
        wr_addr = ADDRW'(y * FB_W + x);
    end

    always_ff @(posedge clk_pix) begin
        if (we && in_fb) begin
            mem[wr_addr] <= cidx;
        end
    end

    assign rd_addr = row_base + fx;

    // screen to fb position by counting SCALE pixels and lines
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            fx       <= '0;
            sub_x    <= '0;
            row_base <= '0;
            sub_y    <= '0;
        end else begin
            if (raster.de) begin
                if (sub_x == SUBW'(SCALE - 1)) begin
                    sub_x <= '0;
                    fx    <= fx + 1'b1;
                end else begin
                    sub_x <= sub_x + 1'b1;
                end
            end else begin
                sub_x <= '0;
                fx    <= '0;
            end
            if (raster.vsync) begin
                sub_y    <= '0;
                row_base <= '0;
            end else if (de_q && !raster.de) begin  // active line just ended
                if (sub_y == SUBW'(SCALE - 1)) begin
                    sub_y    <= '0;
                    row_base <= row_base + ADDRW'(FB_W);
                end else begin
                    sub_y <= sub_y + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        rd_idx <= mem[rd_addr];
    end

    always_comb begin
        rgb   = PALETTE[rd_idx];
        red   = rgb[11:8];
        green = rgb[7:4];
        blue  = rgb[3:0];
    end

    // sync and enable follow the memory and palette stages
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            de_q    <= 1'b0;
            pix     <= '0;
        end else begin
            hsync_q   <= raster.hsync;
            vsync_q   <= raster.vsync;
            de_q      <= raster.de;
            pix.hsync <= hsync_q;
            pix.vsync <= vsync_q;
            pix.de    <= de_q;
            pix.red   <= de_q ? {red, red} : '0;  // black in blanking
            pix.green <= de_q ? {green, green} : '0;
            pix.blue  <= de_q ? {blue, blue} : '0;
        end
    end

endmodule

// ==== verilog/line_sequencer.sv ====
`timescale 1ns/1ns

// one line command at a time, strobes while busy are dropped
// drawing starts on the frame after the command is taken
module line_sequencer import line_pkg::*; (
    input  logic      clk_pix,
    input  logic      rst_n,
    input  line_cmd_t cmd,
    input  logic      cmd_stb,
    input  logic      frame,
    input  logic      done,
    output logic      busy,
    output logic      draw_start,
    output line_cmd_t line
);

    draw_state_t state;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state      <= IDLE;
            draw_start <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_stb) begin
                        state <= WAIT_FRAME;
                    end
                end
                WAIT_FRAME: begin
                    if (frame) begin
                        state      <= DRAW;
                        draw_start <= 1'b1;  // high in the first DRAW cycle
                    end
                end
                DRAW: begin
                    if (done) begin
                        state <= DONE;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // command register, held until the next accepted strobe
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && cmd_stb) begin
            line <= cmd;
        end
    end

    assign busy = (state != IDLE);

endmodule

// ==== verilog/top_line.sv ====
`timescale 1ns/1ns

// line drawing into an indexed framebuffer with scaled raster output
// wait for busy low before the next cmd_stb, earlier strobes are lost
module top_line import line_pkg::*; #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FP     = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BP     = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FP     = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BP     = 20,
    parameter int SCALE    = 4
) (
    input  logic      clk_pix,
    input  logic      rst_n,
    input  line_cmd_t cmd,
    input  logic      cmd_stb,
    output logic      busy,
    output pix_out_t  pix
);

    raster_t   raster;
    line_cmd_t line;        // command being drawn
    logic      draw_start;
    logic      drawing;
    logic      draw_done;
    coord_t    fb_x, fb_y;  // current point from the engine

    display_timings #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) display_timings_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .raster  (raster)
    );

    line_sequencer line_sequencer_inst (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_stb    (cmd_stb),
        .frame      (raster.frame),
        .done       (draw_done),
        .busy       (busy),
        .draw_start (draw_start),
        .line       (line)
    );

    draw_line draw_line_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .start   (draw_start),
        .x0      (line.x0),
        .y0      (line.y0),
        .x1      (line.x1),
        .y1      (line.y1),
        .x       (fb_x),
        .y       (fb_y),
        .drawing (drawing),
        .done    (draw_done)
    );

    framebuffer #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .SCALE    (SCALE)
    ) framebuffer_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .raster  (raster),
        .we      (drawing),
        .x       (fb_x),
        .y       (fb_y),
        .cidx    (line.cidx),
        .pix     (pix)
    );

endmodule

// ==== testbench/tb_top_line.sv ====
`timescale 1ns/1ns

// tiny 32x24 screen with SCALE 2, so the framebuffer is 16x12
// frames are only compared once the drawer is idle again
module tb_top_line import line_pkg::*;;

    localparam int H_ACTIVE = 32;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 2;
    localparam int V_ACTIVE = 24;
    localparam int V_FP     = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 2;
    localparam int SCALE    = 2;
    localparam int FB_W     = H_ACTIVE / SCALE;
    localparam int FB_H     = V_ACTIVE / SCALE;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int NUM_CMDS   = 20;  // every strobe, ignored one included
    localparam int TIMEOUT_CYCLES = (NUM_CMDS + 2) * 3 * H_TOTAL * V_TOTAL;

    logic      clk_pix = 1'b0;
    logic      rst_n;
    line_cmd_t cmd;
    logic      cmd_stb;
    logic      busy;
    pix_out_t  pix;

    cidx_t       ref_fb [FB_H][FB_W];  // expected colour index per fb pixel
    logic [31:0] lfsr_state = 32'h4ba1;
    int          cycle_count = 0;

    top_line #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP),
        .SCALE    (SCALE)
    ) UUT (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .cmd     (cmd),
        .cmd_stb (cmd_stb),
        .busy    (busy),
        .pix     (pix)
    );

    always #4 clk_pix = ~clk_pix;

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, expected);
        stop_with_failure();
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        stop_with_failure();
    endtask

    always @(posedge clk_pix) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout, the test did not finish in time");
        end
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    function automatic logic [23:0] widen_rgb(input logic [11:0] c);
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    function automatic void plot_point(input int x, input int y, input int c);
        if (x >= 0 && x < FB_W && y >= 0 && y < FB_H) begin
            ref_fb[y][x] = cidx_t'(c);  // off-screen points vanish
        end
    endfunction

    // reference bresenham, returns the number of points visited
    function automatic int model_line(input int x0, input int y0, input int x1,
                                      input int y1, input int c);
        int x, y, dx, dy, sx, sy, err, e2, n;
        x   = x0;
        y   = y0;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
        sx  = (x0 < x1) ? 1 : -1;
        sy  = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        for (n = 1; n <= 64; n++) begin
            plot_point(x, y, c);
            if (x == x1 && y == y1) begin
                break;
            end
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
        return n;
    endfunction

    task automatic check_sync_low();
        assert (pix.de == 1'b0) else value_error("pix.de", pix.de, 0);
        assert (pix.hsync == 1'b0) else value_error("pix.hsync", pix.hsync, 0);
        assert (pix.vsync == 1'b0) else value_error("pix.vsync", pix.vsync, 0);
        assert (busy == 1'b0) else value_error("busy", busy, 0);
    endtask

    // one whole frame from the end of vsync, sampled on falling edges
    task automatic check_frame();
        int          de_lines;
        int          vs_cycles;
        int          de_cnt;
        int          hs_cnt;
        logic [23:0] got_rgb;
        logic [23:0] exp_rgb;
        de_lines  = 0;
        vs_cycles = 0;
        @(negedge clk_pix);
        while (!pix.vsync) @(negedge clk_pix);
        while (pix.vsync) @(negedge clk_pix);
        for (int ln = 0; ln < V_TOTAL; ln++) begin
            de_cnt = 0;
            hs_cnt = 0;
            for (int h = 0; h < H_TOTAL; h++) begin
                got_rgb = {pix.red, pix.green, pix.blue};
                if (pix.de) begin
                    assert (de_lines < V_ACTIVE && de_cnt < H_ACTIVE)
                        else report_failure("de is high outside the active area");
                    exp_rgb = widen_rgb(PALETTE[ref_fb[de_lines / SCALE][de_cnt / SCALE]]);
                    assert (got_rgb == exp_rgb) else value_error("pix.rgb", got_rgb, exp_rgb);
                    de_cnt++;
                end else begin
                    assert (got_rgb == '0) else value_error("pix.rgb", got_rgb, 0);
                end
                hs_cnt    += int'(pix.hsync);
                vs_cycles += int'(pix.vsync);
                @(negedge clk_pix);
            end
            assert (de_cnt == 0 || de_cnt == H_ACTIVE)
                else value_error("pix.de cycles per line", de_cnt, H_ACTIVE);
            assert (hs_cnt == H_SYNC) else value_error("pix.hsync cycles per line", hs_cnt, H_SYNC);
            if (de_cnt > 0) begin
                de_lines++;
            end
        end
        assert (de_lines == V_ACTIVE) else value_error("active lines", de_lines, V_ACTIVE);
        assert (vs_cycles == V_SYNC * H_TOTAL)
            else value_error("pix.vsync cycles", vs_cycles, V_SYNC * H_TOTAL);
    endtask

    task automatic send_line(input int x0, input int y0, input int x1, input int y1,
                             input int c);
        int npts;
        int span;
        npts = model_line(x0, y0, x1, y1, c);
        span = ((x1 > x0) ? x1 - x0 : x0 - x1);
        if (((y1 > y0) ? y1 - y0 : y0 - y1) > span) begin
            span = (y1 > y0) ? y1 - y0 : y0 - y1;
        end
        assert (npts == span + 1) else report_failure("reference model lost its endpoint");
        @(posedge clk_pix);
        #1;
        assert (busy == 1'b0) else value_error("busy", busy, 0);
        cmd.x0   = coord_t'(x0);
        cmd.y0   = coord_t'(y0);
        cmd.x1   = coord_t'(x1);
        cmd.y1   = coord_t'(y1);
        cmd.cidx = cidx_t'(c);
        cmd_stb  = 1'b1;
        @(posedge clk_pix);
        #1;
        cmd_stb = 1'b0;
        assert (busy == 1'b1) else value_error("busy", busy, 1);  // one cycle after strobe
    endtask

    // must be dropped by the DUT, so the model stays untouched
    task automatic strobe_while_busy(input int x0, input int y0, input int x1, input int y1,
                                     input int c);
        @(posedge clk_pix);
        #1;
        assert (busy == 1'b1) else report_failure("DUT went idle before the extra strobe");
        cmd.x0   = coord_t'(x0);
        cmd.y0   = coord_t'(y0);
        cmd.x1   = coord_t'(x1);
        cmd.y1   = coord_t'(y1);
        cmd.cidx = cidx_t'(c);
        cmd_stb  = 1'b1;
        @(posedge clk_pix);
        #1;
        cmd_stb = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk_pix);
            #1;
        end
    endtask

    initial begin
        int rx0, ry0, rx1, ry1, rc;
        rst_n   = 1'b0;
        cmd     = '0;
        cmd_stb = 1'b0;
        for (int yy = 0; yy < FB_H; yy++) begin
            for (int xx = 0; xx < FB_W; xx++) begin
                ref_fb[yy][xx] = '0;
            end
        end
        for (int i = 0; i < 3; i++) begin
            @(posedge clk_pix);
            #1;
            check_sync_low();
        end
        rst_n = 1'b1;
        @(posedge clk_pix);
        #1;
        check_sync_low();  // first cycle out of reset

        check_frame();  // blank screen

        send_line(1, 3, 12, 3, 1);    // horizontal
        wait_idle();
        check_frame();
        send_line(5, 0, 5, 11, 2);    // vertical
        wait_idle();
        check_frame();
        send_line(0, 0, 11, 11, 3);   // diagonal
        wait_idle();
        check_frame();
        send_line(14, 10, 2, 4, 4);   // reversed, shallow
        wait_idle();
        check_frame();
        send_line(9, 11, 7, 1, 5);    // reversed, steep
        wait_idle();
        check_frame();
        send_line(15, 0, 15, 0, 6);   // single point
        wait_idle();
        check_frame();
        send_line(-2, -2, 17, 13, 7); // clipped at both ends
        wait_idle();
        check_frame();
        send_line(17, 6, -2, 5, 8);
        wait_idle();
        check_frame();

        // later command wins where lines cross
        send_line(1, 3, 12, 3, 9);
        wait_idle();
        check_frame();
        send_line(3, 0, 3, 11, 10);
        wait_idle();
        check_frame();

        send_line(0, 5, 15, 5, 11);
        strobe_while_busy(0, 8, 15, 8, 12);
        wait_idle();
        check_frame();

        for (int i = 0; i < 8; i++) begin
            rx0 = -2 + take_bits(5) % 20;
            ry0 = -2 + take_bits(4);
            rx1 = -2 + take_bits(5) % 20;
            ry1 = -2 + take_bits(4);
            rc  = take_bits(4);
            send_line(rx0, ry0, rx1, ry1, rc);
            wait_idle();
            check_frame();
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== top_line.f ====
verilog/line_pkg.sv
verilog/display_timings.sv
verilog/draw_line.sv
verilog/framebuffer.sv
verilog/line_sequencer.sv
verilog/top_line.sv
testbench/tb_top_line.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top_line \
		-f top_line.f -Mdir obj_dir -o sim_top_line
	./obj_dir/sim_top_line | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
